// ==== hw/rvPkg.sv ====
package rvPkg;

    localparam int xlen     = 32;
    localparam int memWords = 256;
    localparam int memAw    = 8;      // word address bits, log2(memWords)

    // major opcodes of the supported subset
    localparam logic [6:0] opRtype  = 7'b0110011;   // add sub and or
    localparam logic [6:0] opItype  = 7'b0010011;   // addi
    localparam logic [6:0] opLoad   = 7'b0000011;   // lw
    localparam logic [6:0] opStore  = 7'b0100011;   // sw
    localparam logic [6:0] opBranch = 7'b1100011;   // beq

    localparam logic [2:0] f3Add = 3'b000;
    localparam logic [2:0] f3And = 3'b111;
    localparam logic [2:0] f3Or  = 3'b110;
    localparam logic [6:0] f7Sub = 7'b0100000;      // funct7 that turns add into sub

    // operand source select for the execute stage
    localparam logic [1:0] fwdNone = 2'b00;         // register file value from decode
    localparam logic [1:0] fwdWb   = 2'b01;         // write-back result
    localparam logic [1:0] fwdMem  = 2'b10;         // memory stage result

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    // s and b immediates come out of the r view, funct7 holds the top bits and rd the low ones
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrU;

endpackage

// ==== hw/memBus.sv ====
interface memBus;
    import rvPkg::*;

    logic             reqValid;   // request offered
    logic             reqReady;   // memory side can take it
    logic [memAw-1:0] addr;       // word address
    logic             we;
    logic [xlen-1:0]  wdata;
    logic             rspValid;   // one cycle pulse after an accepted read
    logic [xlen-1:0]  rdata;

    modport requester (
        output reqValid, addr, we, wdata,
        input  reqReady, rspValid, rdata
    );

    modport memory (
        input  reqValid, addr, we, wdata,
        output reqReady, rspValid, rdata
    );

endinterface

// ==== hw/hazardUnit.sv ====
module hazardUnit (
    input  logic [4:0] rs1D,          // sources of the instr in decode
    input  logic [4:0] rs2D,
    input  logic [4:0] rs1E,          // sources of the instr in execute
    input  logic [4:0] rs2E,
    input  logic [4:0] rdE,
    input  logic [4:0] rdM,
    input  logic [4:0] rdW,
    input  logic       memReadE,      // load sitting in execute
    input  logic       regWriteM,
    input  logic       regWriteW,
    input  logic       branchTakenE,  // beq resolved taken this cycle
    output logic [1:0] forwardA,
    output logic [1:0] forwardB,
    output logic       stallD,
    output logic       flushD,
    output logic       flushE
);
    import rvPkg::*;

    logic loadUse;

    // memory stage result is newer, so it wins over write-back
    function automatic logic [1:0] fwdSel(input logic [4:0] rs);
        if (regWriteM && (rdM != 5'd0) && (rdM == rs)) begin
            return fwdMem;
        end
        if (regWriteW && (rdW != 5'd0) && (rdW == rs)) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    always_comb begin
        forwardA = fwdSel(rs1E);
        forwardB = fwdSel(rs2E);
    end

    // load result only exists after the memory stage, decode consumer waits one cycle
    assign loadUse = memReadE && (rdE != 5'd0) && ((rdE == rs1D) || (rdE == rs2D));

    assign stallD = loadUse && !branchTakenE;   // a taken branch kills the consumer anyway
    assign flushD = branchTakenE;
    assign flushE = branchTakenE || loadUse;    // bubble into execute on a stall too

endmodule

// ==== hw/memArbiter.sv ====
module memArbiter (
    input logic      clk,
    input logic      rstN,
    memBus.memory    fetchPort,
    memBus.memory    dataPort,
    memBus.requester memPort
);

    logic grantData;   // data side owns the port this cycle
    logic rspToData;   // owner of the response due this cycle

    assign grantData = dataPort.reqValid;

    // winner's request straight through, no queueing
    assign memPort.reqValid = dataPort.reqValid || fetchPort.reqValid;
    assign memPort.addr     = grantData ? dataPort.addr  : fetchPort.addr;
    assign memPort.we       = grantData ? dataPort.we    : fetchPort.we;
    assign memPort.wdata    = grantData ? dataPort.wdata : fetchPort.wdata;

    assign dataPort.reqReady  = memPort.reqReady;
    assign fetchPort.reqReady = memPort.reqReady && !dataPort.reqValid;   // loses on contention

    // remember who was accepted so the read data goes back to the right side
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rspToData <= 1'b0;
        end else if (memPort.reqValid && memPort.reqReady) begin
            rspToData <= grantData;
        end
    end

    assign dataPort.rspValid  = memPort.rspValid && rspToData;
    assign fetchPort.rspValid = memPort.rspValid && !rspToData;
    assign dataPort.rdata     = memPort.rdata;   // only meaningful with rspValid
    assign fetchPort.rdata    = memPort.rdata;

endmodule

// ==== hw/unifiedMem.sv ====
module unifiedMem (
    input logic   clk,
    memBus.memory port
);
    import rvPkg::*;

    logic [xlen-1:0] mem [memWords];   // code and data share this array

    initial begin
        $readmemh("verif/prog.hex", mem);
    end

    assign port.reqReady = 1'b1;   // single cycle access, never busy

    always_ff @(posedge clk) begin
        if (port.reqValid && port.we) begin
            mem[port.addr] <= port.wdata;
        end
        port.rdata    <= mem[port.addr];            // read path registered
        port.rspValid <= port.reqValid && !port.we; // writes get no response
    end

endmodule

// ==== hw/rvCore.sv ====
module rvCore (
    input  logic                   clk,
    input  logic                   rstN,
    memBus.requester               fetchPort,
    memBus.requester               dataPort,
    output logic                   retireValid,
    output logic [4:0]             retireRd,
    output logic [rvPkg::xlen-1:0] retireData,
    output logic                   halted
);
    import rvPkg::*;

    logic [xlen-1:0] pc;         // next fetch byte address
    logic [xlen-1:0] pcPend;     // address of the fetch in flight or buffered
    logic [xlen-1:0] fBuf;       // fetched word parked while decode is busy
    logic fPend, fDrop, fHave;
    logic fetchAcc, fetchRsp, fetchOutValid, takeD, redirect, freeze;
    logic [xlen-1:0] fetchOutInstr;

    logic validD;
    logic [xlen-1:0] pcD;
    instrU instrD;
    logic [4:0] rs1D, rs2D;
    logic regWriteD, memReadD, memWriteD, branchD, aluSrcD, subD;
    logic [2:0] f3D;
    logic [xlen-1:0] immD, rd1D, rd2D;
    logic [xlen-1:0] rf [32];

    logic validE, regWriteE, memReadE, memWriteE, branchE, aluSrcE, subE;
    logic [xlen-1:0] pcE, immE, rd1E, rd2E;
    logic [4:0] rs1E, rs2E, rdE;
    logic [2:0] f3E;
    logic [xlen-1:0] fwdA, fwdB, aluB, aluOutE, targetE;
    logic branchTakenE, haltE;

    logic validM, regWriteM, memReadM, memWriteM, haltM, dWait, memAccess, memDone;
    logic [4:0] rdM;
    logic [xlen-1:0] aluOutM, writeDataM, resultM;

    logic validW, regWriteW, haltW, wNew, wbWrite;
    logic [4:0] rdW;
    logic [xlen-1:0] resultW;

    logic [1:0] forwardA, forwardB;
    logic stallD, flushD, flushE;

    hazardUnit hazard (
        .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E),
        .rdE(rdE), .rdM(rdM), .rdW(rdW),
        .memReadE(validE && memReadE),
        .regWriteM(validM && regWriteM),
        .regWriteW(validW && regWriteW),
        .branchTakenE(branchTakenE),
        .forwardA(forwardA), .forwardB(forwardB),
        .stallD(stallD), .flushD(flushD), .flushE(flushE)
    );

    // fetch issues one request per pc and the next only after the word has a home
    assign fetchPort.reqValid = rstN && !fPend && !fHave;   // no fetch while reset is held
    assign fetchPort.addr     = pc[memAw+1:2];
    assign fetchPort.we       = 1'b0;
    assign fetchPort.wdata    = '0;
    assign fetchAcc      = fetchPort.reqValid && fetchPort.reqReady;
    assign fetchRsp      = fetchPort.rspValid && !fDrop;     // wrong path words are dropped
    assign fetchOutValid = fHave || fetchRsp;
    assign fetchOutInstr = fHave ? fBuf : fetchPort.rdata;
    assign takeD         = !freeze && !stallD;
    assign redirect      = flushD && !freeze;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc    <= '0;
            fPend <= 1'b0;
            fDrop <= 1'b0;
            fHave <= 1'b0;
        end else begin
            if (redirect) pc <= targetE;
            else if (fetchAcc) pc <= pc + 32'd4;
            if (fetchAcc) fPend <= 1'b1;
            else if (fetchPort.rspValid) fPend <= 1'b0;
            // a request issued before the redirect still has a response coming
            if (redirect) fDrop <= fetchAcc || (fPend && !fetchPort.rspValid);
            else if (fetchPort.rspValid) fDrop <= 1'b0;
            if (redirect) fHave <= 1'b0;
            else if (fetchRsp && !takeD) fHave <= 1'b1;
            else if (takeD) fHave <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchAcc) pcPend <= pc;
        if (fetchRsp) fBuf <= fetchPort.rdata;
    end

    // decode
    assign rs1D = instrD.r.rs1;
    assign rs2D = instrD.r.rs2;
    always_comb begin
        regWriteD = 1'b0;
        memReadD  = 1'b0;
        memWriteD = 1'b0;
        branchD   = 1'b0;
        aluSrcD   = 1'b1;                // immediate operand unless r-type or beq
        subD      = 1'b0;
        f3D       = f3Add;
        immD      = {{20{instrD.i.imm[11]}}, instrD.i.imm};
        case (instrD.r.opcode)
            opRtype: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b0;
                f3D       = instrD.r.funct3;
                subD      = instrD.r.funct7 == f7Sub;
            end
            opItype: begin
                regWriteD = 1'b1;
                f3D       = instrD.i.funct3;
            end
            opLoad: begin
                regWriteD = 1'b1;
                memReadD  = 1'b1;
            end
            opStore: begin
                memWriteD = 1'b1;
                immD = {{20{instrD.r.funct7[6]}}, instrD.r.funct7, instrD.r.rd};
            end
            opBranch: begin
                branchD = 1'b1;
                aluSrcD = 1'b0;
                immD = {{19{instrD.r.funct7[6]}}, instrD.r.funct7[6], instrD.r.rd[0],
                        instrD.r.funct7[5:0], instrD.r.rd[4:1], 1'b0};
            end
            default: ;                   // anything else runs as a nop
        endcase
    end

    // register read with the write-back value bypassed in the same cycle
    assign wbWrite = validW && regWriteW && (rdW != 5'd0);
    assign rd1D = (rs1D == 5'd0) ? '0 : (wbWrite && rdW == rs1D) ? resultW : rf[rs1D];
    assign rd2D = (rs2D == 5'd0) ? '0 : (wbWrite && rdW == rs2D) ? resultW : rf[rs2D];

    always_ff @(posedge clk) begin
        if (wbWrite) rf[rdW] <= resultW;
    end

    // execute
    always_comb begin
        case (forwardA)
            fwdMem:  fwdA = resultM;
            fwdWb:   fwdA = resultW;
            default: fwdA = rd1E;
        endcase
        case (forwardB)
            fwdMem:  fwdB = resultM;
            fwdWb:   fwdB = resultW;
            default: fwdB = rd2E;
        endcase
        aluB = aluSrcE ? immE : fwdB;
        case (f3E)
            f3And:   aluOutE = fwdA & aluB;
            f3Or:    aluOutE = fwdA | aluB;
            default: aluOutE = subE ? fwdA - aluB : fwdA + aluB;
        endcase
    end
    assign targetE      = pcE + immE;
    assign branchTakenE = validE && branchE && (fwdA == fwdB);
    assign haltE        = branchTakenE && (targetE == pcE);   // beq to itself ends the program

    // memory stage access holds the whole pipe until it is done
    assign memAccess         = validM && (memReadM || memWriteM);
    assign dataPort.reqValid = memAccess && !dWait;
    assign dataPort.addr     = aluOutM[memAw+1:2];
    assign dataPort.we       = memWriteM;
    assign dataPort.wdata    = writeDataM;
    assign memDone = !memAccess || (memWriteM ? dataPort.reqReady : dataPort.rspValid);
    assign freeze  = !memDone;
    assign resultM = memReadM ? dataPort.rdata : aluOutM;   // load data valid when it leaves

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dWait  <= 1'b0;
            validD <= 1'b0;
            validE <= 1'b0;
            validM <= 1'b0;
            validW <= 1'b0;
            wNew   <= 1'b0;
            halted <= 1'b0;
        end else begin
            if (dataPort.rspValid) dWait <= 1'b0;
            else if (dataPort.reqValid && dataPort.reqReady && !memWriteM) dWait <= 1'b1;
            if (!freeze) begin
                if (flushD) validD <= 1'b0;
                else if (!stallD) validD <= fetchOutValid;
                validE <= validD && !flushE;
                validM <= validE;
                validW <= validM;
            end
            wNew <= !freeze;             // w holds during a freeze so it retires only once
            if (validW && haltW) halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (takeD) begin
            instrD <= fetchOutInstr;
            pcD    <= pcPend;
        end
        if (!freeze) begin
            pcE        <= pcD;
            rs1E       <= rs1D;
            rs2E       <= rs2D;
            rdE        <= instrD.r.rd;
            rd1E       <= rd1D;
            rd2E       <= rd2D;
            immE       <= immD;
            regWriteE  <= regWriteD;
            memReadE   <= memReadD;
            memWriteE  <= memWriteD;
            branchE    <= branchD;
            aluSrcE    <= aluSrcD;
            subE       <= subD;
            f3E        <= f3D;
            regWriteM  <= regWriteE;
            memReadM   <= memReadE;
            memWriteM  <= memWriteE;
            rdM        <= rdE;
            aluOutM    <= aluOutE;
            writeDataM <= fwdB;          // store data after forwarding
            haltM      <= haltE;
            regWriteW  <= regWriteM;
            rdW        <= rdM;
            resultW    <= resultM;
            haltW      <= haltM;
        end
    end

    assign retireValid = wbWrite && wNew;
    assign retireRd    = rdW;
    assign retireData  = resultW;

endmodule

// ==== hw/rvTop.sv ====
module rvTop (
    input  logic                   clk,
    input  logic                   rstN,
    output logic                   retireValid,
    output logic [4:0]             retireRd,
    output logic [rvPkg::xlen-1:0] retireData,
    output logic                   halted
);

    memBus fetchBus ();   // core fetch side to arbiter
    memBus dataBus ();    // core load/store side to arbiter
    memBus ramBus ();     // arbiter to the single ram port

    rvCore core (
        .clk(clk),
        .rstN(rstN),
        .fetchPort(fetchBus.requester),
        .dataPort(dataBus.requester),
        .retireValid(retireValid),
        .retireRd(retireRd),
        .retireData(retireData),
        .halted(halted)
    );

    memArbiter arb (
        .clk(clk),
        .rstN(rstN),
        .fetchPort(fetchBus.memory),
        .dataPort(dataBus.memory),
        .memPort(ramBus.requester)
    );

    unifiedMem ram (
        .clk(clk),
        .port(ramBus.memory)
    );

endmodule

// ==== verif/coreChecker.sv ====
module coreChecker (
    input logic                   clk,
    input logic                   rstN,
    input logic                   retireValid,
    input logic [4:0]             retireRd,
    input logic [rvPkg::xlen-1:0] retireData,
    input logic                   halted
);
    import rvPkg::*;

    logic [4:0]      expRd   [16];   // only the first 12 entries are used
    logic [xlen-1:0] expData [16];
    logic [3:0]      idx;            // next table entry
    logic badRd = 1'b0;
    logic badData = 1'b0;
    logic badZero = 1'b0;
    logic badFlushed = 1'b0;
    logic badHaltDrop = 1'b0;
    logic badLateRetire = 1'b0;
    logic failed;

    // retire order of prog.hex, values follow from the instruction semantics
    initial begin
        expRd[0]  = 5'd1;   expData[0]  = 32'd5;    // addi x1 = 0 + 5
        expRd[1]  = 5'd2;   expData[1]  = 32'd10;   // add x2 = 5 + 5
        expRd[2]  = 5'd3;   expData[2]  = 32'd5;    // sub x3 = 10 - 5
        expRd[3]  = 5'd4;   expData[3]  = 32'd5;    // lw x4, stored x3
        expRd[4]  = 5'd5;   expData[4]  = 32'd10;   // add x5 = 5 + 5
        expRd[5]  = 5'd6;   expData[5]  = 32'd1;    // after the untaken beq
        expRd[6]  = 5'd8;   expData[6]  = 32'd3;    // branch target
        expRd[7]  = 5'd9;   expData[7]  = 32'd5;    // add x9 = 0 + 5
        expRd[8]  = 5'd10;  expData[8]  = 32'd0;    // 1010 and 0101
        expRd[9]  = 5'd11;  expData[9]  = 32'd15;   // 1010 or 0101
        expRd[10] = 5'd12;  expData[10] = 32'd16;   // addi x12 = 15 + 1
        expRd[11] = 5'd13;  expData[11] = 32'd26;   // add x13 = 16 + 10
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idx <= 4'd0;
        end else if (retireValid) begin
            idx <= idx + 4'd1;
        end
    end

    assign failed = badRd | badData | badZero | badFlushed | badHaltDrop | badLateRetire;

    rdInOrder: assert property (@(posedge clk) disable iff (!rstN)
        retireValid && idx < 4'd12 |-> retireRd == expRd[idx])
        else begin
            badRd = 1'b1;
            $error("ERROR %0t retireRd got %0d expected %0d",
                   $time, $sampled(retireRd), expRd[$sampled(idx)]);
        end

    dataInOrder: assert property (@(posedge clk) disable iff (!rstN)
        retireValid && idx < 4'd12 |-> retireData == expData[idx])
        else begin
            badData = 1'b1;
            $error("ERROR %0t retireData got %0d expected %0d",
                   $time, $sampled(retireData), expData[$sampled(idx)]);
        end

    noX0Write: assert property (@(posedge clk) disable iff (!rstN)
        retireValid |-> retireRd != 5'd0)
        else begin
            badZero = 1'b1;
            $error("a retire reported a write to x0");
        end

    // both x7 writes sit in the shadow of the taken beq
    noFlushedRetire: assert property (@(posedge clk) disable iff (!rstN)
        retireValid |-> retireRd != 5'd7)
        else begin
            badFlushed = 1'b1;
            $error("an instruction after the taken branch retired to x7");
        end

    haltSticky: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted)
        else begin
            badHaltDrop = 1'b1;
            $error("halted dropped after it was set");
        end

    noRetireAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !retireValid)
        else begin
            badLateRetire = 1'b1;
            $error("a retire happened after halted was set");
        end

endmodule

bind rvTop coreChecker chk (
    .clk(clk),
    .rstN(rstN),
    .retireValid(retireValid),
    .retireRd(retireRd),
    .retireData(retireData),
    .halted(halted)
);

// ==== verif/tbTop.sv ====
module tbTop;
    import rvPkg::*;

    logic            clk;
    logic            rstN;
    logic            retireValid;
    logic [4:0]      retireRd;
    logic [xlen-1:0] retireData;
    logic            halted;
    int              retireCount = 0;   // write-backs seen at the top ports
    int              cycles;

    rvTop uut (
        .clk(clk),
        .rstN(rstN),
        .retireValid(retireValid),
        .retireRd(retireRd),
        .retireData(retireData),
        .halted(halted)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;   // 8 unit period

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on the first failure");
    endtask

    // outputs settle long before the falling edge
    always @(negedge clk) begin
        if (rstN && retireValid) begin
            retireCount++;
        end
        if (uut.chk.failed) begin
            abortRun("an assertion on the retire stream failed in coreChecker");
        end
    end

    initial begin
        rstN = 1'b0;
        repeat (5) @(negedge clk);   // reset held for 5 cycles
        rstN = 1'b1;
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            abortRun("the core never raised halted within 2000 cycles");
        end else begin
            // short window so the checker sees halted hold with no late retire
            cycles = 0;
            while (cycles < 10) begin
                @(negedge clk);
                cycles++;
            end
            if (retireCount != 12) begin   // register writes in prog.hex
                abortRun($sformatf("ERROR %0t retireCount got %0d expected %0d",
                                   $time, retireCount, 12));
            end else begin
                $display("Simulation finished: PASS");
                $finish;
            end
        end
    end

endmodule

// ==== verif/prog.hex ====
// one 32-bit instruction word per line, word address 0 upward
// byte address and assembly in the trailing comment
00500093 // 00 addi x1, x0, 5
00108133 // 04 add  x2, x1, x1
401101B3 // 08 sub  x3, x2, x1
08302023 // 0c sw   x3, 0x80(x0)
08002203 // 10 lw   x4, 0x80(x0)
001202B3 // 14 add  x5, x4, x1
00208463 // 18 beq  x1, x2, +8  (not taken)
00100313 // 1c addi x6, x0, 1
00118663 // 20 beq  x3, x1, +12 (taken to 2c)
00700393 // 24 addi x7, x0, 7
00700393 // 28 addi x7, x0, 7
00300413 // 2c addi x8, x0, 3
00900013 // 30 addi x0, x0, 9
001004B3 // 34 add  x9, x0, x1
00117533 // 38 and  x10, x2, x1
001165B3 // 3c or   x11, x2, x1
00158613 // 40 addi x12, x11, 1
005606B3 // 44 add  x13, x12, x5
00000063 // 48 beq  x0, x0, 0 (halt)
00000013 // 4c nop
00000013 // 50 nop

// ==== build.f ====
hw/rvPkg.sv
hw/memBus.sv
hw/hazardUnit.sv
hw/memArbiter.sv
hw/unifiedMem.sv
hw/rvCore.sv
hw/rvTop.sv
verif/coreChecker.sv
verif/tbTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the core testbench with verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbTop -f build.f -o simTb > build.log 2>&1
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $buildStatus"
    exit 1
fi

# assertion errors are counted so the testbench can report the failure itself
./obj_dir/simTb +verilator+error+limit+100 > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Simulation finished: PASS" sim.log; then
    exit 0
fi
echo "pass line missing from sim.log"
exit 1
